// ==== filelist.f ====
k2mm_pkg.sv
kernel_ram.sv
axpby_kernel.sv
out_fifo.sv
xor_reducer.sv
k2mm_top.sv
tb_k2mm.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_k2mm -o sim_k2mm

out=$(./obj_dir/sim_k2mm)
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
    exit 0
fi
exit 1

// ==== tb_k2mm.sv ====
`timescale 1ns/1ns

module tb_k2mm
    import k2mm_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic  ap_clk = 1'b0;
    logic  rst;
    logic  ap_start;
    word_t alpha;
    word_t beta;
    logic  load_en;
    logic  load_op;
    lane_t load_lane;
    addr_t load_addr;
    word_t load_data;
    logic  drain_en;
    logic  ap_done;
    logic  ap_idle;
    logic  ap_ready;
    sig_t  data_out;
    logic  data_valid;

    // host copies of the operand banks
    word_t a_m [LANES][BANK_DEPTH];
    word_t b_m [LANES][BANK_DEPTH];
    word_t rng_state = 32'hf0fe;
    sig_t  sig_acc = '0;
    int    dv_count = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    k2mm_top i_dut (
        .ap_clk(ap_clk), .rst(rst), .ap_start(ap_start),
        .alpha(alpha), .beta(beta),
        .load_en(load_en), .load_op(load_op), .load_lane(load_lane),
        .load_addr(load_addr), .load_data(load_data), .drain_en(drain_en),
        .ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
        .data_out(data_out), .data_valid(data_valid)
    );

    always #10 ap_clk = ~ap_clk;

    // running xor of every output nibble
    always @(negedge ap_clk)
    begin
        if (data_valid === 1'b1)
        begin
            sig_acc  <= sig_acc ^ data_out;
            dv_count <= dv_count + 1;
        end
    end

    function automatic word_t xorshift32(input word_t x);
        word_t s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_word(output word_t v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // whole-run signature from the host copies
    function automatic sig_t model_signature(input word_t alpha_v, input word_t beta_v);
        word_t      e;
        logic [7:0] acc;
        acc = 8'h00;
        for (int l = 0; l < LANES; l++)
        begin
            for (int k = 0; k < BANK_DEPTH; k++)
            begin
                e = alpha_v * a_m[l][k] + beta_v * b_m[l][k];
                for (int j = 0; j < 4; j++)
                begin
                    acc = acc ^ e[8*j +: 8];
                end
            end
        end
        return sig_t'(acc[7:4] ^ acc[3:0]);
    endfunction

    task automatic load_operands();
        word_t v;
        if (ap_idle !== 1'b1)
        begin
            $display("CHECK FAILED ap_idle got %h exp %h", ap_idle, 1'b1);
            errors++;
        end
        for (int op = 0; op < 2; op++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                for (int k = 0; k < BANK_DEPTH; k++)
                begin
                    next_word(v);
                    if (op == 0)
                        a_m[l][k] = v;
                    else
                        b_m[l][k] = v;
                    load_en   = 1'b1;
                    load_op   = (op == 1);
                    load_lane = lane_t'(l);
                    load_addr = addr_t'(k);
                    load_data = v;
                    @(negedge ap_clk);
                end
            end
        end
        load_en = 1'b0;
        next_word(alpha);
        next_word(beta);
    endtask

    task automatic set_drain(input int mode);
        word_t r;
        next_word(r);
        drain_en = (mode == 1) || ((mode == 2) && ((r % 32'd10) < 32'd3));
    endtask

    // mode 1 drain high, 2 random, after an optional held-low phase
    task automatic run_once(input int mode, input int hold_cycles);
        sig_t expected;
        sig_t start_sig;
        bit   seen;
        int   n;
        int   count0;
        int   ready_count;
        expected = model_signature(alpha, beta);
        start_sig = sig_acc;
        ready_count = 0;
        ap_start = 1'b1;
        @(negedge ap_clk);
        ap_start = 1'b0;
        for (int i = 0; i < hold_cycles; i++)
        begin
            drain_en = 1'b0;
            @(negedge ap_clk);
            if (ap_done !== 1'b0 || data_valid !== 1'b0)
            begin
                $display("CHECK FAILED ap_done/data_valid got %h exp %h",
                         {ap_done, data_valid}, 2'h0);
                errors++;
            end
            if (ap_ready === 1'b1)
            begin
                ready_count++;
            end
        end
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT)
        begin
            set_drain(mode);
            @(negedge ap_clk);
            if (ap_ready === 1'b1)
            begin
                ready_count++;
            end
            seen = (ap_done === 1'b1);
            n++;
        end
        if (!seen)
        begin
            $display("timed out waiting for ap_done");
            errors++;
        end
        // one ready pulse per run, with the last read
        if (ready_count != 1)
        begin
            $display("CHECK FAILED ap_ready pulses got %h exp %h", ready_count, 1);
            errors++;
        end
        @(negedge ap_clk);
        if (ap_idle !== 1'b1)
        begin
            $display("CHECK FAILED ap_idle got %h exp %h", ap_idle, 1'b1);
            errors++;
        end
        // empty the fifos, then expect silence
        drain_en = 1'b1;
        repeat (20) @(negedge ap_clk);
        count0 = dv_count;
        repeat (10) @(negedge ap_clk);
        if (dv_count != count0)
        begin
            $display("data_valid still pulsing after the FIFOs were drained");
            errors++;
        end
        if ((sig_acc ^ start_sig) !== expected)
        begin
            $display("CHECK FAILED data_out signature got %h exp %h",
                     sig_acc ^ start_sig, expected);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("test %0d %s: ok", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial
    begin
        int e0;
        rst = 1'b1;
        ap_start = 1'b0;
        alpha = '0;
        beta = '0;
        load_en = 1'b0;
        load_op = 1'b0;
        load_lane = '0;
        load_addr = '0;
        load_data = '0;
        drain_en = 1'b0;
        repeat (16) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;

        // ##############################
        e0 = errors;
        if (ap_idle !== 1'b1)
        begin
            $display("CHECK FAILED ap_idle got %h exp %h", ap_idle, 1'b1);
            errors++;
        end
        repeat (10)
        begin
            @(negedge ap_clk);
            if (ap_done !== 1'b0 || ap_ready !== 1'b0 || data_valid !== 1'b0)
            begin
                $display("CHECK FAILED done/ready/valid got %h exp %h",
                         {ap_done, ap_ready, data_valid}, 3'h0);
                errors++;
            end
        end
        report("reset state", e0);

        e0 = errors;
        load_operands();
        run_once(1, 0);
        report("single run", e0);

        e0 = errors;
        load_operands();
        run_once(2, 0);
        report("back-pressure run", e0);

        e0 = errors;
        load_operands();
        run_once(1, 200);
        report("held drain", e0);

        // ##############################
        e0 = errors;
        for (int r = 0; r < 3; r++)
        begin
            load_operands();
            run_once(2, 0);
        end
        report("back-to-back runs", e0);

        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== k2mm_top.sv ====
`timescale 1ns/1ns

module k2mm_top
    import k2mm_pkg::*;
(
    input  logic  ap_clk,
    input  logic  rst,
    input  logic  ap_start,
    input  word_t alpha,
    input  word_t beta,
    input  logic  load_en,
    input  logic  load_op,
    input  lane_t load_lane,
    input  addr_t load_addr,
    input  word_t load_data,
    input  logic  drain_en,
    output logic  ap_done,
    output logic  ap_idle,
    output logic  ap_ready,
    output sig_t  data_out,
    output logic  data_valid
);

    logic             a_ce;
    logic             b_ce;
    addr_t            rd_addr;
    word_t            a_q [LANES];
    word_t            b_q [LANES];
    word_t            e_din [LANES];
    logic [LANES-1:0] e_write;
    logic [LANES-1:0] full_n;
    logic [LANES-1:0] empty_n;
    logic [LANES-1:0] pop;
    word_t            head [LANES];

    // ##############################
    // operand banks and lane fifos
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        kernel_ram #(.OP_SEL(1'b0), .LANE_ID(lane_t'(i))) i_a_ram (
            .ap_clk(ap_clk), .rst(rst),
            .load_en(load_en), .load_op(load_op), .load_lane(load_lane),
            .load_addr(load_addr), .load_data(load_data),
            .ce(a_ce), .addr(rd_addr), .q(a_q[i])
        );

        kernel_ram #(.OP_SEL(1'b1), .LANE_ID(lane_t'(i))) i_b_ram (
            .ap_clk(ap_clk), .rst(rst),
            .load_en(load_en), .load_op(load_op), .load_lane(load_lane),
            .load_addr(load_addr), .load_data(load_data),
            .ce(b_ce), .addr(rd_addr), .q(b_q[i])
        );

        out_fifo i_fifo (
            .ap_clk(ap_clk), .rst(rst),
            .e_din(e_din[i]), .e_write(e_write[i]), .full_n(full_n[i]),
            .pop(pop[i]), .head(head[i]), .empty_n(empty_n[i])
        );
    end

    // ##############################
    // kernel
    axpby_kernel i_kernel (
        .ap_clk(ap_clk), .rst(rst), .ap_start(ap_start),
        .alpha(alpha), .beta(beta),
        .ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
        .a_ce(a_ce), .b_ce(b_ce), .addr(rd_addr),
        .a_q(a_q), .b_q(b_q), .full_n(full_n),
        .e_din(e_din), .e_write(e_write)
    );

    // signature output
    xor_reducer i_reducer (
        .ap_clk(ap_clk), .rst(rst), .drain_en(drain_en),
        .empty_n(empty_n), .head(head), .pop(pop),
        .data_out(data_out), .data_valid(data_valid)
    );

endmodule

// ==== xor_reducer.sv ====
`timescale 1ns/1ns

module xor_reducer
    import k2mm_pkg::*;
(
    input  logic             ap_clk,
    input  logic             rst,
    input  logic             drain_en,
    input  logic [LANES-1:0] empty_n,
    input  word_t            head [LANES],
    output logic [LANES-1:0] pop,
    output sig_t             data_out,
    output logic             data_valid
);

    logic [7:0]       xor_1 [LANES];
    logic [LANES-1:0] valid_1;
    logic [7:0]       xor_2 [2];
    logic [1:0]       valid_2;
    logic [7:0]       xor_3;
    logic             valid_3;

    // bytewise fold of one word
    function automatic logic [7:0] fold_word(input word_t w);
        return w[7:0] ^ w[15:8] ^ w[23:16] ^ w[31:24];
    endfunction

    // only valid inputs take part, zero if neither
    function automatic logic [7:0] merge(
        input logic       v0,
        input logic [7:0] x0,
        input logic       v1,
        input logic [7:0] x1
    );
        return ({8{v0}} & x0) ^ ({8{v1}} & x1);
    endfunction

    assign pop = {LANES{drain_en}} & empty_n;

    // ##############################
    // valid pipeline
    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            valid_1    <= '0;
            valid_2    <= '0;
            valid_3    <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            valid_1    <= pop;
            valid_2[0] <= valid_1[0] | valid_1[1];
            valid_2[1] <= valid_1[2] | valid_1[3];
            valid_3    <= valid_2[0] | valid_2[1];
            data_valid <= valid_3;
        end
    end

    // ##############################
    // data pipeline
    always_ff @(posedge ap_clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            xor_1[i] <= fold_word(head[i]);
        end
        xor_2[0] <= merge(valid_1[0], xor_1[0], valid_1[1], xor_1[1]);
        xor_2[1] <= merge(valid_1[2], xor_1[2], valid_1[3], xor_1[3]);
        xor_3    <= merge(valid_2[0], xor_2[0], valid_2[1], xor_2[1]);
        data_out <= xor_3[7:4] ^ xor_3[3:0];
    end

endmodule

// ==== out_fifo.sv ====
`timescale 1ns/1ns

module out_fifo
    import k2mm_pkg::*;
(
    input  logic  ap_clk,
    input  logic  rst,
    input  word_t e_din,
    input  logic  e_write,
    output logic  full_n,
    input  logic  pop,
    output word_t head,
    output logic  empty_n
);

    word_t   buf_mem [FIFO_DEPTH];
    fptr_t   wr_ptr;
    fptr_t   rd_ptr;
    fcount_t count;
    logic    do_wr;
    logic    do_rd;

    assign do_wr = e_write && (count != fcount_t'(FIFO_DEPTH));
    assign do_rd = pop && empty_n;

    // show-ahead head
    assign head    = buf_mem[rd_ptr];
    assign empty_n = (count != '0);
    assign full_n  = (count <= FULL_LEVEL);

    always_ff @(posedge ap_clk)
    begin
        if (do_wr)
        begin
            buf_mem[wr_ptr] <= e_din;
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fcount_t'(do_wr) - fcount_t'(do_rd);
        end
    end

endmodule

// ==== axpby_kernel.sv ====
`timescale 1ns/1ns

module axpby_kernel
    import k2mm_pkg::*;
(
    input  logic             ap_clk,
    input  logic             rst,
    input  logic             ap_start,
    input  word_t            alpha,
    input  word_t            beta,
    output logic             ap_done,
    output logic             ap_idle,
    output logic             ap_ready,
    output logic             a_ce,
    output logic             b_ce,
    output addr_t            addr,
    input  word_t            a_q [LANES],
    input  word_t            b_q [LANES],
    input  logic [LANES-1:0] full_n,
    output word_t            e_din [LANES],
    output logic [LANES-1:0] e_write
);

    kstate_t state;
    logic    issue;
    logic    last;
    logic    rd_valid;

    // ##############################
    // read issue

    // every lane must have room, one result is still in flight
    assign issue = (state == RUN) && (&full_n);
    assign last  = (addr == LAST_ADDR);

    assign a_ce = issue;
    assign b_ce = issue;

    assign ap_ready = issue && last;
    assign ap_done  = (state == DONE);
    assign ap_idle  = (state == IDLE);

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            state    <= IDLE;
            addr     <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= issue;
            case (state)
                IDLE:
                begin
                    if (ap_start)
                    begin
                        state <= RUN;
                        addr  <= '0;
                    end
                end
                RUN:
                begin
                    if (issue)
                    begin
                        addr <= addr + 1'b1;
                        if (last)
                        begin
                            state <= DRAIN;
                        end
                    end
                end
                // last result gets written here
                DRAIN:
                begin
                    state <= DONE;
                end
                DONE:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ##############################
    // lane arithmetic

    // low 32 bits of alpha*a + beta*b
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            e_din[i] = alpha * a_q[i] + beta * b_q[i];
        end
    end

    assign e_write = {LANES{rd_valid}};

endmodule

// ==== kernel_ram.sv ====
`timescale 1ns/1ns

module kernel_ram
    import k2mm_pkg::*;
#(
    parameter bit    OP_SEL  = 1'b0,
    parameter lane_t LANE_ID = '0
)
(
    input  logic  ap_clk,
    input  logic  rst,
    input  logic  load_en,
    input  logic  load_op,
    input  lane_t load_lane,
    input  addr_t load_addr,
    input  word_t load_data,
    input  logic  ce,
    input  addr_t addr,
    output word_t q
);

    word_t mem [BANK_DEPTH];
    logic  sel;

    // only the bank matching operand and lane takes the host write
    assign sel = load_en && (load_op == OP_SEL) && (load_lane == LANE_ID);

    always_ff @(posedge ap_clk)
    begin
        if (sel)
        begin
            mem[load_addr] <= load_data;
        end
    end

    // one cycle read for the kernel
    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            q <= '0;
        end
        else if (ce)
        begin
            q <= mem[addr];
        end
    end

endmodule

// ==== k2mm_pkg.sv ====
package k2mm_pkg;

    // ##############################
    // partitioning and sizes
    localparam int LANES      = 4;
    localparam int BANK_DEPTH = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // ##############################
    // data types
    typedef logic [3:0]  addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  lane_t;
    typedef logic [3:0]  sig_t;

    // fifo pointer and fill level
    typedef logic [FIFO_AW-1:0] fptr_t;
    typedef logic [FIFO_AW:0]   fcount_t;

    // last element of a bank
    localparam addr_t LAST_ADDR = addr_t'(BANK_DEPTH - 1);

    // room for the write in flight plus one more
    localparam fcount_t FULL_LEVEL = fcount_t'(FIFO_DEPTH - 2);

    // ##############################
    // kernel control
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } kstate_t;

endpackage
